//--- hdl/cpuIsaPkg.sv
// Instruction set definitions for the 16-bit load/store core
// Opcodes, register and word types, branch conditions and flags

package cpuIsaPkg;

  localparam int numRegs   = 16;  // R0 reads as zero
  localparam int bOffWidth = 9;   // B offset field, in halfwords

  typedef logic [15:0] wordT;     // Data or address word
  typedef logic [3:0]  regIdxT;   // Register index

  // Top nibble of every instruction
  typedef enum logic [3:0] {
    ADD    = 4'h0,
    SUB    = 4'h1,
    XOR    = 4'h2,
    RED    = 4'h3,   // Decodes as no-op
    SLL    = 4'h4,
    SRA    = 4'h5,
    ROR    = 4'h6,
    PADDSB = 4'h7,   // Decodes as no-op
    LW     = 4'h8,
    SW     = 4'h9,
    LLB    = 4'hA,
    LHB    = 4'hB,
    B      = 4'hC,
    BR     = 4'hD,
    PCS    = 4'hE,
    HLT    = 4'hF
  } opcodeT;

  // Branch condition, instr[11:9]
  typedef enum logic [2:0] {
    condNe     = 3'b000,  // Z clear
    condEq     = 3'b001,  // Z set
    condGt     = 3'b010,  // Z and N clear
    condLt     = 3'b011,  // N set
    condGe     = 3'b100,
    condLe     = 3'b101,
    condOv     = 3'b110,  // V set
    condAlways = 3'b111
  } condT;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flagsT;

endpackage

//--- hdl/cpuPipePkg.sv
// Pipeline payloads, control word and forwarding selects
// Each stage register carries one of these structs

package cpuPipePkg;
  import cpuIsaPkg::*;

  // Control word from decode, rides along to W
  typedef struct packed {
    logic regWrEn;    // Writes a register in W
    logic memToReg;   // Load, result from data memory
    logic memWr;      // Store
    logic aluSrc;     // ALU B from immediate
    logic dstSel;     // 1 = rd, 0 = rt
    logic branch;     // B or BR
    logic setsFlags;  // Updates the flag register in E
  } ctrlT;

  // Source of an operand after forwarding
  typedef enum logic [1:0] {
    fwdReg = 2'b00,  // Straight from the register read
    fwdE   = 2'b01,  // ALU result in E, D target only
    fwdM   = 2'b10,
    fwdW   = 2'b11
  } fwdSelT;

  typedef struct packed {
    logic valid;
    logic halt;
    wordT instr;
    wordT pcPlus2;
  } ifIdT;

  typedef struct packed {
    logic   valid;
    logic   halt;
    opcodeT opcode;
    ctrlT   ctrl;
    wordT   srcA;     // rs data or PC+2 for PCS
    wordT   srcB;
    regIdxT rd;
    regIdxT rs;
    regIdxT rt;
    wordT   imm;
  } idExT;

  typedef struct packed {
    logic   valid;
    logic   halt;
    ctrlT   ctrl;
    regIdxT dstReg;
    wordT   aluOut;   // Result or data address
    wordT   storeData;
  } exMemT;

  typedef struct packed {
    logic   valid;
    logic   halt;
    logic   regWrEn;
    logic   memToReg;
    regIdxT dstReg;
    wordT   aluOut;
    wordT   loadData;
  } memWbT;

endpackage

//--- hdl/hazardIf.sv
// Signals between the pipeline stages and the hazard unit
// Core drives register indices and strobes, unit returns stalls and selects
`timescale 1ns/10ps

interface hazardIf import cpuIsaPkg::*, cpuPipePkg::*;;
  // Stage side
  regIdxT rsD, rtD;
  logic   branchD, isBrD, branchTakenD;  // branchD only when flags matter
  regIdxT rsE, rtE, dstRegE;
  logic   regWrEnE, memToRegE, setsFlagsE;
  regIdxT dstRegM, dstRegW;
  logic   regWrEnM, memToRegM, regWrEnW;

  // Unit side
  logic   stallF, stallD, flushD;
  fwdSelT fwdD, fwdAE, fwdBE;

  modport stages (
    output rsD, rtD, branchD, isBrD, branchTakenD,
    output rsE, rtE, dstRegE, regWrEnE, memToRegE, setsFlagsE,
    output dstRegM, regWrEnM, memToRegM, dstRegW, regWrEnW,
    input  stallF, stallD, flushD, fwdD, fwdAE, fwdBE
  );

  modport unit (
    input  rsD, rtD, branchD, isBrD, branchTakenD,
    input  rsE, rtE, dstRegE, regWrEnE, memToRegE, setsFlagsE,
    input  dstRegM, regWrEnM, memToRegM, dstRegW, regWrEnW,
    output stallF, stallD, flushD, fwdD, fwdAE, fwdBE
  );

endinterface

//--- hdl/stageReg.sv
// Pipeline register between two stages, one per payload struct
// clr wins over en so a stalled stage can be turned into a bubble
`timescale 1ns/10ps

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    en,   // Low holds the current payload
  input  logic    clr,  // Loads an invalid all-zero payload
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;
    end else if (clr) begin
      q <= '0;        // Bubble
    end else if (en) begin
      q <= d;
    end
  end

endmodule

//--- hdl/regFile.sv
// Sixteen-entry register file, two read ports and one write port
// Write data bypasses to the reads so D sees W's result in the same cycle
`timescale 1ns/10ps

module regFile import cpuIsaPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  regIdxT rs,
  input  regIdxT rt,
  input  regIdxT wrIdx,
  input  logic   wrEn,
  input  wordT   wrData,
  output wordT   rsData,
  output wordT   rtData
);

  wordT regs [numRegs];  // Entry 0 never written

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrIdx != '0) begin
      regs[wrIdx] <= wrData;
    end
  end

  // R0 first, then the write in flight, then storage
  assign rsData = (rs == '0) ? '0 :
                  (wrEn && wrIdx == rs) ? wrData : regs[rs];
  assign rtData = (rt == '0) ? '0 :
                  (wrEn && wrIdx == rt) ? wrData : regs[rt];

endmodule

//--- hdl/controlDecode.sv
// Decode stage logic: control word, register fields, immediate
// Also resolves B/BR conditions against the flag register
`timescale 1ns/10ps

module controlDecode import cpuIsaPkg::*, cpuPipePkg::*; (
  input  wordT   instr,
  input  flagsT  flags,
  output opcodeT opcode,
  output ctrlT   ctrl,
  output regIdxT rs,
  output regIdxT rt,
  output regIdxT rd,
  output wordT   imm,
  output condT   cond,
  output logic   branchTaken
);

  logic isByteLoad;  // LLB or LHB
  logic condPass;

  assign opcode     = opcodeT'(instr[15:12]);
  assign isByteLoad = (opcode == LLB) || (opcode == LHB);
  assign cond       = condT'(instr[11:9]);

  always_comb begin
    ctrl = '0;  // RED, PADDSB and HLT do nothing
    case (opcode)
      ADD, SUB, XOR: begin
        ctrl.regWrEn   = 1'b1;
        ctrl.dstSel    = 1'b1;
        ctrl.setsFlags = 1'b1;
      end
      SLL, SRA, ROR: begin
        ctrl.regWrEn   = 1'b1;
        ctrl.dstSel    = 1'b1;
        ctrl.aluSrc    = 1'b1;  // Shift amount
        ctrl.setsFlags = 1'b1;
      end
      LW: begin
        ctrl.regWrEn  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      SW:       {ctrl.memWr, ctrl.aluSrc} = 2'b11;
      LLB, LHB: {ctrl.regWrEn, ctrl.aluSrc, ctrl.dstSel} = 3'b111;
      B, BR:    ctrl.branch = 1'b1;
      PCS:      {ctrl.regWrEn, ctrl.dstSel} = 2'b11;
      default:  ;
    endcase
  end

  assign rd = instr[11:8];
  // Byte loads modify rd in place; PCS reads nothing so forwarding stays off
  assign rs = isByteLoad ? instr[11:8] : (opcode == PCS) ? '0 : instr[7:4];
  assign rt = instr[15] ? instr[11:8] : instr[3:0];  // Store data lives in rd slot

  assign imm = isByteLoad ? {{8{instr[7]}}, instr[7:0]} : {12'd0, instr[3:0]};

  always_comb begin
    case (cond)
      condNe:  condPass = ~flags.z;
      condEq:  condPass = flags.z;
      condGt:  condPass = ~flags.z & ~flags.n;
      condLt:  condPass = flags.n;
      condGe:  condPass = flags.z | ~flags.n;  // GT or EQ
      condLe:  condPass = flags.z | flags.n;
      condOv:  condPass = flags.v;
      default: condPass = 1'b1;
    endcase
  end

  assign branchTaken = ctrl.branch & condPass;

endmodule

//--- hdl/aluCompute.sv
// Execute-stage ALU with the Z/V/N flag register
// Flags written at the edge that ends E, per-flag by opcode
`timescale 1ns/10ps

module aluCompute import cpuIsaPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  opcodeT opcode,
  input  logic   valid,  // Bubbles leave the flags alone
  input  wordT   a,
  input  wordT   b,
  output wordT   result,
  output flagsT  flags
);

  logic signed [16:0] sumWide;  // One guard bit for overflow
  logic               ovf;
  wordT               satOut;
  logic [31:0]        rotWide;
  logic [3:0]         shamt;
  logic               wrZ;       // XOR, shifts, ADD, SUB
  logic               wrVn;      // ADD, SUB only

  assign shamt = b[3:0];

  assign sumWide = (opcode == SUB) ? {a[15], a} - {b[15], b}
                                   : {a[15], a} + {b[15], b};
  assign ovf     = sumWide[16] ^ sumWide[15];
  assign satOut  = !ovf ? sumWide[15:0] :
                   sumWide[16] ? 16'h8000 : 16'h7FFF;  // Clamp by true sign

  assign rotWide = {a, a} >> shamt;

  always_comb begin
    case (opcode)
      ADD, SUB: result = satOut;
      XOR:      result = a ^ b;
      SLL:      result = a << shamt;
      SRA:      result = wordT'($signed(a) >>> shamt);
      ROR:      result = rotWide[15:0];
      LW, SW:   result = (a + {b[14:0], 1'b0}) & 16'hFFFE;  // Word aligned
      LLB:      result = {a[15:8], b[7:0]};
      LHB:      result = {b[7:0], a[7:0]};
      default:  result = a;  // PCS passes PC+2, no-ops pass rs
    endcase
  end

  assign wrVn = (opcode == ADD) || (opcode == SUB);
  assign wrZ  = wrVn || (opcode == XOR) || (opcode == SLL) ||
                (opcode == SRA) || (opcode == ROR);

  ////////////////////////////////////////////////////////////
  // Flag register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (valid) begin
      if (wrZ) begin
        flags.z <= (result == '0);
      end
      if (wrVn) begin
        flags.v <= ovf;
        flags.n <= result[15];  // Sign after saturation
      end
    end
  end

endmodule

//--- hdl/hazardUnit.sv
// Stall, flush and forwarding decisions for the five-stage pipeline
// Purely combinational, sits on the core's hazardIf
`timescale 1ns/10ps

module hazardUnit import cpuIsaPkg::*, cpuPipePkg::*; (
  hazardIf.unit hz
);

  logic loadUse;   // Load in E feeds D
  logic flagWait;  // Branch needs flags still being made in E
  logic brLoad;    // BR target is a load in flight
  logic stall;

  // E operand source, M beats W since it is younger
  function automatic fwdSelT selE(input regIdxT src);
    fwdSelT sel;
    sel = fwdReg;
    if (hz.regWrEnM && hz.dstRegM != '0 && hz.dstRegM == src)
      sel = fwdM;
    else if (hz.regWrEnW && hz.dstRegW != '0 && hz.dstRegW == src)
      sel = fwdW;
    return sel;
  endfunction

  assign hz.fwdAE = selE(hz.rsE);
  assign hz.fwdBE = selE(hz.rtE);

  assign loadUse = hz.memToRegE && hz.dstRegE != '0 &&
                   (hz.dstRegE == hz.rsD || hz.dstRegE == hz.rtD);
  assign flagWait = hz.branchD && hz.setsFlagsE;
  assign brLoad = hz.isBrD && hz.rsD != '0 &&
                  ((hz.memToRegE && hz.dstRegE == hz.rsD) ||
                   (hz.memToRegM && hz.dstRegM == hz.rsD));

  assign stall     = loadUse | flagWait | brLoad;
  assign hz.stallF = stall;
  assign hz.stallD = stall;
  assign hz.flushD = hz.branchTakenD & ~stall;  // Kill the one fetched behind

  // BR target forward, loads never picked here since they stall
  always_comb begin
    hz.fwdD = fwdReg;
    if (hz.rsD != '0) begin
      if (hz.regWrEnE && !hz.memToRegE && hz.dstRegE == hz.rsD)
        hz.fwdD = fwdE;
      else if (hz.regWrEnM && hz.dstRegM == hz.rsD)
        hz.fwdD = fwdM;
      else if (hz.regWrEnW && hz.dstRegW == hz.rsD)
        hz.fwdD = fwdW;
    end
  end

endmodule

//--- hdl/cpu.sv
// Top level of the five-stage pipelined core (F, D, E, M, W)
// Instruction and data memories sit outside and answer in the same cycle
`timescale 1ns/10ps

module cpu import cpuIsaPkg::*, cpuPipePkg::*; (
  input  logic clk,
  input  logic arstN,
  output wordT instrAddr,
  input  wordT instr,
  output wordT dataAddr,
  output wordT dataWr,
  input  wordT dataRd,
  output logic dataWrEn,
  output logic dataRdEn,
  output logic hlt,
  output wordT pcOut
);

  hazardIf hz ();
  hazardUnit hazardUnit_inst (.hz(hz));

  ifIdT   ifIdD, ifIdQ;
  idExT   idExD, idExQ;
  exMemT  exMemD, exMemQ;
  memWbT  memWbD, memWbQ;
  wordT   aluOutE, resultW;  // Forwarding sources

  ////////////////////////////////////////////////////////////
  // F
  ////////////////////////////////////////////////////////////
  wordT pc, pcNext, pcPlus2F, targetD;
  logic haltF, branchTakenD;

  assign haltF    = (instr[15:12] == HLT);
  assign pcPlus2F = pc + 16'd2;
  // Taken branch beats halt, halt spins on its own address
  assign pcNext   = branchTakenD ? targetD : haltF ? pc : pcPlus2F;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (!hz.stallF) begin
      pc <= pcNext;
    end
  end

  assign instrAddr = pc;
  assign pcOut     = pc;
  assign ifIdD     = '{valid: 1'b1, halt: haltF, instr: instr, pcPlus2: pcPlus2F};

  stageReg #(.payloadT(ifIdT)) ifIdReg (
    .clk(clk), .arstN(arstN), .en(!hz.stallD), .clr(hz.flushD), .d(ifIdD), .q(ifIdQ)
  );

  ////////////////////////////////////////////////////////////
  // D
  ////////////////////////////////////////////////////////////
  opcodeT opcodeD;
  ctrlT   ctrlDec, ctrlD;
  regIdxT rsD, rtD, rdD;
  wordT   immD, rsData, rtData, bTargetD, brTargetD;
  condT   condD;
  logic   takenDec;
  flagsT  flags;

  controlDecode controlDecode_inst (
    .instr(ifIdQ.instr), .flags(flags), .opcode(opcodeD), .ctrl(ctrlDec),
    .rs(rsD), .rt(rtD), .rd(rdD), .imm(immD), .cond(condD), .branchTaken(takenDec)
  );

  regFile regFile_inst (
    .clk(clk), .arstN(arstN), .rs(rsD), .rt(rtD),
    .wrIdx(memWbQ.dstReg), .wrEn(memWbQ.valid & memWbQ.regWrEn), .wrData(resultW),
    .rsData(rsData), .rtData(rtData)
  );

  assign ctrlD        = ifIdQ.valid ? ctrlDec : '0;  // Flushed slot does nothing
  assign branchTakenD = ifIdQ.valid & takenDec;

  // PC+2 plus sign-extended halfword offset
  assign bTargetD = ifIdQ.pcPlus2 +
                    {{(15 - bOffWidth){ifIdQ.instr[8]}}, ifIdQ.instr[8:0], 1'b0};

  always_comb begin
    case (hz.fwdD)
      fwdE:    brTargetD = aluOutE;
      fwdM:    brTargetD = exMemQ.aluOut;
      fwdW:    brTargetD = resultW;
      default: brTargetD = rsData;
    endcase
  end
  assign targetD = (opcodeD == BR) ? brTargetD : bTargetD;

  assign hz.rsD         = rsD;
  assign hz.rtD         = rtD;
  assign hz.branchD     = ctrlD.branch && condD != condAlways;  // Only if flags matter
  assign hz.isBrD       = ifIdQ.valid && opcodeD == BR;
  assign hz.branchTakenD = branchTakenD;

  assign idExD = '{valid: ifIdQ.valid, halt: ifIdQ.halt, opcode: opcodeD, ctrl: ctrlD,
                   srcA: (opcodeD == PCS) ? ifIdQ.pcPlus2 : rsData,  // PCS result path
                   srcB: rtData, rd: rdD, rs: rsD, rt: rtD, imm: immD};

  stageReg #(.payloadT(idExT)) idExReg (
    .clk(clk), .arstN(arstN), .en(1'b1), .clr(hz.stallD), .d(idExD), .q(idExQ)
  );

  ////////////////////////////////////////////////////////////
  // E
  ////////////////////////////////////////////////////////////
  wordT   fwdA, fwdB, aluB;
  regIdxT dstRegE;

  always_comb begin
    case (hz.fwdAE)
      fwdM:    fwdA = exMemQ.aluOut;
      fwdW:    fwdA = resultW;
      default: fwdA = idExQ.srcA;
    endcase
    case (hz.fwdBE)
      fwdM:    fwdB = exMemQ.aluOut;
      fwdW:    fwdB = resultW;
      default: fwdB = idExQ.srcB;
    endcase
  end

  assign aluB    = idExQ.ctrl.aluSrc ? idExQ.imm : fwdB;
  assign dstRegE = idExQ.ctrl.dstSel ? idExQ.rd : idExQ.rt;

  aluCompute aluCompute_inst (
    .clk(clk), .arstN(arstN), .opcode(idExQ.opcode), .valid(idExQ.valid),
    .a(fwdA), .b(aluB), .result(aluOutE), .flags(flags)
  );

  assign hz.rsE        = idExQ.rs;
  assign hz.rtE        = idExQ.rt;
  assign hz.dstRegE    = dstRegE;
  assign hz.regWrEnE   = idExQ.ctrl.regWrEn;
  assign hz.memToRegE  = idExQ.ctrl.memToReg;
  assign hz.setsFlagsE = idExQ.ctrl.setsFlags;

  assign exMemD = '{valid: idExQ.valid, halt: idExQ.halt, ctrl: idExQ.ctrl,
                    dstReg: dstRegE, aluOut: aluOutE, storeData: fwdB};

  stageReg #(.payloadT(exMemT)) exMemReg (
    .clk(clk), .arstN(arstN), .en(1'b1), .clr(1'b0), .d(exMemD), .q(exMemQ)
  );

  ////////////////////////////////////////////////////////////
  // M
  ////////////////////////////////////////////////////////////
  assign dataAddr = exMemQ.aluOut;
  assign dataWr   = exMemQ.storeData;
  assign dataWrEn = exMemQ.valid & exMemQ.ctrl.memWr;
  assign dataRdEn = exMemQ.valid & exMemQ.ctrl.memToReg;

  assign hz.dstRegM   = exMemQ.dstReg;
  assign hz.regWrEnM  = exMemQ.ctrl.regWrEn;
  assign hz.memToRegM = exMemQ.ctrl.memToReg;

  assign memWbD = '{valid: exMemQ.valid, halt: exMemQ.halt,
                    regWrEn: exMemQ.ctrl.regWrEn, memToReg: exMemQ.ctrl.memToReg,
                    dstReg: exMemQ.dstReg, aluOut: exMemQ.aluOut, loadData: dataRd};

  stageReg #(.payloadT(memWbT)) memWbReg (
    .clk(clk), .arstN(arstN), .en(1'b1), .clr(1'b0), .d(memWbD), .q(memWbQ)
  );

  ////////////////////////////////////////////////////////////
  // W
  ////////////////////////////////////////////////////////////
  assign resultW     = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluOut;
  assign hz.dstRegW  = memWbQ.dstReg;
  assign hz.regWrEnW = memWbQ.valid & memWbQ.regWrEn;
  assign hlt         = memWbQ.valid & memWbQ.halt;  // HLT refetched, stays up

endmodule

//--- tests/cpuTb.sv
// Testbench for the pipelined core with memories modeled from tests/cpuPatterns.txt
// Runs the program to HLT, checks every store in order and the final PC
`timescale 1ns/10ps

module cpuTb import cpuIsaPkg::*;;

  localparam int maxCycles = 2000;  // Bound on the wait for hlt

  logic clk;
  logic arstN;
  wordT instrAddr, instr, dataAddr, dataWr, dataRd, pcOut;
  logic dataWrEn, dataRdEn, hlt;

  wordT imem [256];  // Word addressed by addr[8:1]
  wordT dmem [256];
  wordT expAddrQ [$];  // Expected stores in program order
  wordT expDataQ [$];
  wordT haltPc;
  int   errors;
  int   storesSeen;
  int   cycles;

  cpu cpu_inst (
    .clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .dataWr(dataWr), .dataRd(dataRd),
    .dataWrEn(dataWrEn), .dataRdEn(dataRdEn), .hlt(hlt), .pcOut(pcOut)
  );

  // Both memories answer in the same cycle
  assign instr  = imem[instrAddr[8:1]];
  assign dataRd = dataRdEn ? dmem[dataAddr[8:1]] : ~dmem[dataAddr[8:1]];  // Needs the strobe

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk) begin
    if (dataWrEn) begin
      dmem[dataAddr[8:1]] <= dataWr;  // Store commits at the edge
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (arstN && dataWrEn) begin
      checkStore(dataAddr, dataWr);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic checkStore(input wordT addr, input wordT data);
    wordT expAddr;
    wordT expData;
    storesSeen++;
    if (expAddrQ.size() == 0) begin
      errors++;
      $display("FAIL %0t: store %h to %h with no store expected", $time, data, addr);
      return;
    end
    expAddr = expAddrQ.pop_front();
    expData = expDataQ.pop_front();
    if (addr !== expAddr || data !== expData) begin
      errors++;
      $display("FAIL %0t: store %h to %h, expected %h to %h",
               $time, data, addr, expData, expAddr);
    end
  endtask

  task automatic checkHalt(input wordT pc);
    if (pc !== haltPc) begin
      errors++;
      $display("FAIL %0t: halted at pc %h, expected %h", $time, pc, haltPc);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Pattern file
  ////////////////////////////////////////////////////////////
  task automatic loadPatterns();
    integer       fd;
    integer       n;
    reg [8*128-1:0] line;
    reg [7:0]     tag;
    wordT         addr;
    wordT         w [8];
    for (int i = 0; i < 256; i++) begin
      imem[i] = {8'hF0, 8'(i)};          // Unused slots decode as HLT
      dmem[i] = {~8'(i), 8'(i)};
    end
    fd = $fopen("tests/cpuPatterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the pattern file tests/cpuPatterns.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = '0;
      tag  = 8'h00;
      if ($fgets(line, fd) == 0) begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", tag, addr,
                  w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
      case (tag)
        "I": begin
          for (int k = 0; k < n - 2; k++) begin
            imem[8'(addr[8:1] + k)] = w[k];  // Up to eight words per line
          end
        end
        "D": dmem[addr[8:1]] = w[0];
        "S": begin
          expAddrQ.push_back(addr);
          expDataQ.push_back(w[0]);
        end
        "H": haltPc = addr;
        default: ;  // Comments and blank lines
      endcase
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    arstN      = 1'b0;
    errors     = 0;
    storesSeen = 0;
    haltPc     = '0;
    loadPatterns();
    repeat (8) @(posedge clk);
    #1 arstN = 1'b1;  // Release just after the edge

    cycles = 0;
    while (!hlt && cycles < maxCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!hlt) begin
      errors++;
      $display("Timeout: hlt did not rise within %0d cycles", maxCycles);
    end else begin
      checkHalt(pcOut);
    end

    if (expAddrQ.size() != 0) begin
      errors += expAddrQ.size();
      $display("Missing stores: %0d expected stores never happened", expAddrQ.size());
    end

    $display("Summary: %0d cycles, %0d stores seen, %0d errors", cycles, storesSeen, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tests/cpuPatterns.txt
# I addr w0..w7 : program words from addr on, D addr data : initial data word
# S addr data : expected store in order, H addr : expected halt PC
# ALU, saturation, shifts, byte loads, forwarding into E and store data
I 00 AF80 A1FF B17F A201 0312 93F0 A400 B480
I 10 1542 95F1 2614 4764 5843 6914 96F2 97F3
# Load-use stalls, then branch conditions on zero, negative, overflow, positive
I 20 98F4 99F5 AA40 8BA0 0CB2 9CF6 8DA1 9DF7
I 30 AFA0 AE55 1022 C001 9EF0 C201 9EF1 C401
I 40 9EF2 C601 9EF3 C801 9EF4 CA01 9EF5 CC01
I 50 9EF6 0040 C601 9EF7 C801 9EF8 CA01 9EF9
I 60 C401 9EFA 0011 CC01 9EFB C001 9EFC C201
# PCS, BR to a value in E, BR to a loaded value, BR not taken, B always, HLT
I 70 9EFD 0022 C401 9EFE CC01 9EFF E500 A68A
I 80 B600 DE60 9DF0 F086 F088 95F1 87A2 DE70
I 90 9DF0 F092 97F3 1022 D070 92F4 CE01 9DF0
I A0 F000
D 40 1234
D 42 0F0F
D 44 0094
S 80 7FFF
S 82 8000
S 84 FFFF
S 86 FFF0
S 88 F000
S 8A F7FF
S 8C 1235
S 8E 0F0F
S A0 0055
S A4 0055
S A6 0055
S AC 0055
S B0 0055
S B4 0055
S BA 0055
S BE 0055
S A2 007E
S A6 0094
S A8 0001
H A0

//--- cpu.f
hdl/cpuIsaPkg.sv
hdl/cpuPipePkg.sv
hdl/hazardIf.sv
hdl/stageReg.sv
hdl/regFile.sv
hdl/controlDecode.sv
hdl/aluCompute.sv
hdl/hazardUnit.sv
hdl/cpu.sv
tests/cpuTb.sv
